// ==== logic/deskew_pkg.sv ====
`default_nettype none

package deskew_pkg;

	// Lane word format is fixed for the receive path
	localparam int DATA_W = 16;

	typedef logic [DATA_W-1:0] lane_data_t;

	typedef enum logic [1:0]
	{
		ST_INIT,	// Waiting for the first marker
		ST_COUNT,	// Counting until every lane has shown its marker
		ST_DONE		// Lanes aligned, buffers reading
	} deskew_state_t;

endpackage

`default_nettype wire

// ==== logic/deskew_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module deskew_fsm
	import deskew_pkg::*;
#(
	parameter int N_LANES        = 20,
	parameter int MAX_SKEW       = 16,
	parameter int NB_DELAY_COUNT = $clog2(MAX_SKEW + 1)
)
(
	input  wire                      i_clock,
	input  wire                      i_rst_n,
	input  wire                      i_valid,
	input  wire                      i_resync,
	input  wire                      i_am_lock,
	input  wire [N_LANES-1:0]        i_start_of_lane,
	input  wire [NB_DELAY_COUNT-1:0] i_common_counter,

	output logic                     o_enable_counters,
	output logic                     o_stop_common_counter,
	output logic                     o_set_fifo_delay,
	output logic                     o_write_fifo_enb,
	output logic                     o_read_fifo_enb,
	output wire  [N_LANES-1:0]       o_stop_lane_counters,
	output wire                      o_deskew_done,
	output wire                      o_invalid_skew
);

	deskew_state_t      state;
	deskew_state_t      state_next;
	logic [N_LANES-1:0] seen_lanes;
	logic [N_LANES-1:0] seen_lanes_next;
	logic               deskew_done_q;
	logic               sync_clear;

	assign sync_clear = i_resync || !i_am_lock;

	assign o_invalid_skew       = (i_common_counter >= MAX_SKEW);
	assign o_stop_lane_counters = seen_lanes;	// A lane stops counting once its marker is seen
	assign o_deskew_done        = deskew_done_q && !o_invalid_skew;

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			state         <= ST_INIT;
			seen_lanes    <= '0;
			deskew_done_q <= 1'b0;
		end
		else if (i_valid)
		begin
			if (sync_clear)
			begin
				state         <= ST_INIT;
				seen_lanes    <= '0;
				deskew_done_q <= 1'b0;
			end
			else
			begin
				state         <= state_next;
				seen_lanes    <= seen_lanes_next;
				deskew_done_q <= (state == ST_DONE);	// One beat behind entering ST_DONE
			end
		end
	end

	always_comb
	begin
		state_next            = state;
		seen_lanes_next       = seen_lanes;
		o_enable_counters     = 1'b0;
		o_stop_common_counter = 1'b0;
		o_set_fifo_delay      = 1'b0;
		o_write_fifo_enb      = 1'b0;
		o_read_fifo_enb       = 1'b0;

		case (state)
			ST_INIT:
			begin
				if (|i_start_of_lane)
				begin
					state_next      = ST_COUNT;
					seen_lanes_next = i_start_of_lane;
				end
			end

			ST_COUNT:
			begin
				o_enable_counters = 1'b1;
				o_write_fifo_enb  = 1'b1;
				seen_lanes_next   = seen_lanes | i_start_of_lane;

				// Spread too wide, drop what was seen and wait for the next marker
				if (o_invalid_skew)
				begin
					state_next      = ST_INIT;
					seen_lanes_next = '0;
				end
				else if (&seen_lanes)
				begin
					state_next            = ST_DONE;
					o_set_fifo_delay      = 1'b1;
					o_stop_common_counter = 1'b1;
				end
			end

			ST_DONE:
			begin
				o_write_fifo_enb = 1'b1;
				o_read_fifo_enb  = 1'b1;
			end

			default:
			begin
				state_next = ST_INIT;
			end
		endcase
	end

	// Common count holds through the delay load
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_valid && o_set_fifo_delay && !sync_clear)
		|=> (i_common_counter == $past(i_common_counter)));

	// Common count from the counters stays below the limit for as long as done is held
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		deskew_done_q |-> !o_invalid_skew);

endmodule

`default_nettype wire

// ==== logic/skew_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module skew_counters
#(
	parameter int N_LANES        = 20,
	parameter int MAX_SKEW       = 16,
	parameter int NB_DELAY_COUNT = $clog2(MAX_SKEW + 1)
)
(
	input  wire                                i_clock,
	input  wire                                i_rst_n,
	input  wire                                i_valid,
	input  wire                                i_resync,
	input  wire                                i_am_lock,
	input  wire                                i_enable_counters,
	input  wire                                i_stop_common_counter,
	input  wire                                i_set_fifo_delay,
	input  wire [N_LANES-1:0]                  i_stop_lane_counters,

	output wire [NB_DELAY_COUNT-1:0]           o_common_counter,
	output wire [N_LANES*NB_DELAY_COUNT-1:0]   o_lane_delay
);

	logic                      sync_clear;
	logic [NB_DELAY_COUNT-1:0] common_count;

	assign sync_clear       = i_resync || !i_am_lock;
	assign o_common_counter = common_count;

	// Beats since the first marker, held at MAX_SKEW
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			common_count <= '0;
		else if (i_valid)
		begin
			if (sync_clear || !i_enable_counters)
				common_count <= '0;
			else if (!i_stop_common_counter && (common_count < MAX_SKEW))
				common_count <= common_count + 1'b1;
		end
	end

	for (genvar i = 0; i < N_LANES; i++)
	begin : g_lane
		logic [NB_DELAY_COUNT-1:0] lane_count;
		logic [NB_DELAY_COUNT-1:0] delay_q;

		always_ff @(posedge i_clock or negedge i_rst_n)
		begin
			if (!i_rst_n)
				lane_count <= '0;
			else if (i_valid)
			begin
				if (sync_clear || !i_enable_counters)
					lane_count <= '0;
				else if (!i_stop_lane_counters[i] && (lane_count < MAX_SKEW))
					lane_count <= lane_count + 1'b1;
			end
		end

		// Beats this lane's marker came ahead of the last one
		always_ff @(posedge i_clock or negedge i_rst_n)
		begin
			if (!i_rst_n)
				delay_q <= '0;
			else if (i_valid)
			begin
				if (sync_clear)
					delay_q <= '0;
				else if (i_set_fifo_delay)
					delay_q <= common_count - lane_count;
			end
		end

		assign o_lane_delay[i*NB_DELAY_COUNT +: NB_DELAY_COUNT] = delay_q;

		assert property (@(posedge i_clock) disable iff (!i_rst_n)
			(i_valid && i_set_fifo_delay && !sync_clear) |=> (delay_q < MAX_SKEW));
	end

endmodule

`default_nettype wire

// ==== logic/lane_delay_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_delay_fifo
	import deskew_pkg::*;
#(
	parameter int MAX_SKEW       = 16,
	parameter int NB_DELAY_COUNT = $clog2(MAX_SKEW + 1)
)
(
	input  wire                      i_clock,
	input  wire                      i_rst_n,
	input  wire                      i_valid,
	input  wire                      i_clear,
	input  wire                      i_write_enb,
	input  wire                      i_read_enb,
	input  wire [NB_DELAY_COUNT-1:0] i_delay,
	input  lane_data_t               i_data,
	input  wire                      i_start,

	output lane_data_t               o_data,
	output logic                     o_start
);

	localparam int PTR_W = (MAX_SKEW > 1) ? $clog2(MAX_SKEW) : 1;
	localparam int SUM_W = NB_DELAY_COUNT + 1;

	logic [DATA_W:0]  mem [MAX_SKEW];	// Marker flag in the top bit
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_addr;
	logic [SUM_W-1:0] rd_sum;
	logic [DATA_W:0]  rd_word;

	// Slot written i_delay beats ago, modulo MAX_SKEW
	always_comb
	begin
		rd_sum = SUM_W'(wr_ptr) + SUM_W'(MAX_SKEW) - SUM_W'(i_delay);
		if (rd_sum >= SUM_W'(MAX_SKEW))
			rd_sum = rd_sum - SUM_W'(MAX_SKEW);
		rd_addr = rd_sum[PTR_W-1:0];
	end

	// Zero delay passes the word being written this beat
	assign rd_word = (i_delay == '0) ? {i_start, i_data} : mem[rd_addr];

	always_ff @(posedge i_clock)
	begin
		if (i_valid && i_write_enb)
			mem[wr_ptr] <= {i_start, i_data};
	end

	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			wr_ptr <= '0;
		else if (i_valid)
		begin
			if (i_clear)
				wr_ptr <= '0;
			else if (i_write_enb)
			begin
				if (wr_ptr == PTR_W'(MAX_SKEW - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid && i_read_enb)
			o_data <= rd_word[DATA_W-1:0];
	end

	// Marker out only on beats that actually read
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_start <= 1'b0;
		else if (i_valid)
			o_start <= i_read_enb && !i_clear && rd_word[DATA_W];
	end

	// Reading only makes sense while the controller keeps writing
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		i_read_enb |-> i_write_enb);

endmodule

`default_nettype wire

// ==== logic/lane_deskew_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_deskew_top
	import deskew_pkg::*;
#(
	parameter int N_LANES        = 20,
	parameter int MAX_SKEW       = 16,
	parameter int NB_DELAY_COUNT = $clog2(MAX_SKEW + 1)	// Must hold MAX_SKEW itself
)
(
	input  wire                        i_clock,
	input  wire                        i_rst_n,
	input  wire                        i_valid,
	input  wire [N_LANES-1:0]          i_lane_start,
	input  wire [N_LANES*DATA_W-1:0]   i_lane_data,
	input  wire                        i_resync,
	input  wire                        i_am_lock,

	output logic                       o_valid,
	output wire [N_LANES*DATA_W-1:0]   o_lane_data,
	output wire [N_LANES-1:0]          o_lane_start,
	output wire                        o_deskew_done,
	output wire                        o_invalid_skew
);

	wire                              enable_counters;
	wire                              stop_common_counter;
	wire                              set_fifo_delay;
	wire                              write_fifo_enb;
	wire                              read_fifo_enb;
	wire [N_LANES-1:0]                stop_lane_counters;
	wire [NB_DELAY_COUNT-1:0]         common_counter;
	wire [N_LANES*NB_DELAY_COUNT-1:0] lane_delay;
	wire                              sync_clear;

	assign sync_clear = i_resync || !i_am_lock;

	deskew_fsm #(
		.N_LANES        (N_LANES),
		.MAX_SKEW       (MAX_SKEW),
		.NB_DELAY_COUNT (NB_DELAY_COUNT)
	) u_fsm (
		.i_clock               (i_clock),
		.i_rst_n               (i_rst_n),
		.i_valid               (i_valid),
		.i_resync              (i_resync),
		.i_am_lock             (i_am_lock),
		.i_start_of_lane       (i_lane_start),
		.i_common_counter      (common_counter),
		.o_enable_counters     (enable_counters),
		.o_stop_common_counter (stop_common_counter),
		.o_set_fifo_delay      (set_fifo_delay),
		.o_write_fifo_enb      (write_fifo_enb),
		.o_read_fifo_enb       (read_fifo_enb),
		.o_stop_lane_counters  (stop_lane_counters),
		.o_deskew_done         (o_deskew_done),
		.o_invalid_skew        (o_invalid_skew)
	);

	skew_counters #(
		.N_LANES        (N_LANES),
		.MAX_SKEW       (MAX_SKEW),
		.NB_DELAY_COUNT (NB_DELAY_COUNT)
	) u_counters (
		.i_clock               (i_clock),
		.i_rst_n               (i_rst_n),
		.i_valid               (i_valid),
		.i_resync              (i_resync),
		.i_am_lock             (i_am_lock),
		.i_enable_counters     (enable_counters),
		.i_stop_common_counter (stop_common_counter),
		.i_set_fifo_delay      (set_fifo_delay),
		.i_stop_lane_counters  (stop_lane_counters),
		.o_common_counter      (common_counter),
		.o_lane_delay          (lane_delay)
	);

	for (genvar i = 0; i < N_LANES; i++)
	begin : g_lane
		lane_delay_fifo #(
			.MAX_SKEW       (MAX_SKEW),
			.NB_DELAY_COUNT (NB_DELAY_COUNT)
		) u_fifo (
			.i_clock     (i_clock),
			.i_rst_n     (i_rst_n),
			.i_valid     (i_valid),
			.i_clear     (sync_clear),
			.i_write_enb (write_fifo_enb),
			.i_read_enb  (read_fifo_enb),
			.i_delay     (lane_delay[i*NB_DELAY_COUNT +: NB_DELAY_COUNT]),
			.i_data      (i_lane_data[i*DATA_W +: DATA_W]),
			.i_start     (i_lane_start[i]),
			.o_data      (o_lane_data[i*DATA_W +: DATA_W]),
			.o_start     (o_lane_start[i])
		);
	end

	// One strobe per aligned beat, lined up with the buffer output registers
	always_ff @(posedge i_clock or negedge i_rst_n)
	begin
		if (!i_rst_n)
			o_valid <= 1'b0;
		else
			o_valid <= i_valid && read_fifo_enb && !sync_clear;
	end

endmodule

`default_nettype wire

// ==== dv/deskew_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module deskew_tb
	import deskew_pkg::*;
();

	localparam int N_LANES     = 4;
	localparam int MAX_SKEW    = 16;
	localparam int CLK_PERIOD  = 4;
	localparam int ALIGN_LIMIT = 120;	// Beats allowed before done must rise
	localparam int CHECK_BEATS = 80;
	localparam int MARKER_GAP  = 32;
	localparam int REF_DEPTH   = 512;
	localparam int TOTAL_BEATS = 8 + 6 * (ALIGN_LIMIT + CHECK_BEATS + 1) + 64;
	localparam int OUT_FREE    = 0;	// o_valid allowed, data checked
	localparam int OUT_NONE    = 1;
	localparam int OUT_LOCKED  = 2;
	localparam logic [31:0] SEED = 32'he87a_e818;

	logic                      i_clock;
	logic                      i_rst_n;
	logic                      i_valid;
	logic [N_LANES-1:0]        i_lane_start;
	logic [N_LANES*DATA_W-1:0] i_lane_data;
	logic                      i_resync;
	logic                      i_am_lock;
	logic                      o_valid;
	wire  [N_LANES*DATA_W-1:0] o_lane_data;
	wire  [N_LANES-1:0]        o_lane_start;
	wire                       o_deskew_done;
	wire                       o_invalid_skew;

	lane_data_t  ref_words [REF_DEPTH];	// Reference stream, index = word number
	int          skew [N_LANES];
	int          max_skew_cfg;
	logic [31:0] rng;
	int          t;
	int          prev_t;
	bit          prev_valid;
	bit          prev_clear;
	int          out_mode;
	int          markers_seen;
	int          errors;
	int          tests_run;

	lane_deskew_top #(
		.N_LANES  (N_LANES),
		.MAX_SKEW (MAX_SKEW)
	) UUT (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_valid        (i_valid),
		.i_lane_start   (i_lane_start),
		.i_lane_data    (i_lane_data),
		.i_resync       (i_resync),
		.i_am_lock      (i_am_lock),
		.o_valid        (o_valid),
		.o_lane_data    (o_lane_data),
		.o_lane_start   (o_lane_start),
		.o_deskew_done  (o_deskew_done),
		.o_invalid_skew (o_invalid_skew)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #(CLK_PERIOD / 2) i_clock = ~i_clock;
	end

	initial
	begin
		#(TOTAL_BEATS * 3 * CLK_PERIOD);
		$display("Watchdog expired at %0d ns, the tests did not complete", $time);
		$display("Checks failed");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic lane_data_t word_at(input int idx);
		if (idx < 0)
			return '0;	// Before the stream starts
		return ref_words[idx % REF_DEPTH];
	endfunction

	function automatic bit marker_at(input int idx);
		return (idx >= 0) && (idx % MARKER_GAP == 0);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0d ns: %s got %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// Outputs now reflect the beat driven in the previous cycle
	task automatic check_outputs();
		int exp_idx;
		exp_idx = prev_t - max_skew_cfg;
		assert (!(o_deskew_done && o_invalid_skew))
		else
		begin
			$display("At %0d ns done and invalid skew were high together", $time);
			errors++;
		end
		if (prev_clear)
		begin
			check_value("o_valid", 32'(o_valid), 32'd0);
			check_value("o_deskew_done", 32'(o_deskew_done), 32'd0);
		end
		if (out_mode == OUT_NONE)
		begin
			check_value("o_valid", 32'(o_valid), 32'd0);
			check_value("o_deskew_done", 32'(o_deskew_done), 32'd0);
		end
		else if (out_mode == OUT_LOCKED)
		begin
			check_value("o_valid", 32'(o_valid), 32'(prev_valid));
			check_value("o_deskew_done", 32'(o_deskew_done), 32'd1);
		end
		if (o_valid)
		begin
			for (int i = 0; i < N_LANES; i++)
			begin
				check_value($sformatf("o_lane_data[%0d]", i),
					32'(o_lane_data[i*DATA_W +: DATA_W]), 32'(word_at(exp_idx)));
				check_value($sformatf("o_lane_start[%0d]", i),
					32'(o_lane_start[i]), 32'(marker_at(exp_idx)));
			end
			if (&o_lane_start)
				markers_seen++;
		end
	endtask

	// One clock: check, then drive a beat, a gap or a clear
	task automatic step(input int gap_pct, input bit resync, input bit lock);
		int idx;
		bit valid;
		bit clear;
		@(posedge i_clock);
		#1;
		check_outputs();
		clear = resync || !lock;
		rng = lcg_next(rng);
		valid = clear || (gap_pct == 0) || (int'(rng[31:24]) % 100 >= gap_pct);
		i_valid   = valid;
		i_resync  = resync;
		i_am_lock = lock;
		for (int i = 0; i < N_LANES; i++)
		begin
			idx = t - skew[i];	// Lane i runs skew[i] words behind
			i_lane_data[i*DATA_W +: DATA_W] = (valid && !clear) ? word_at(idx) : '0;
			i_lane_start[i] = valid && !clear && marker_at(idx);
		end
		prev_valid = valid;
		prev_clear = clear;
		prev_t     = t;
		if (valid && !clear)
			t++;
	endtask

	task automatic set_skews(input int s0, input int s1, input int s2, input int s3);
		skew[0] = s0;
		skew[1] = s1;
		skew[2] = s2;
		skew[3] = s3;
		max_skew_cfg = 0;
		for (int i = 0; i < N_LANES; i++)
			if (skew[i] > max_skew_cfg)
				max_skew_cfg = skew[i];
	endtask

	task automatic start_test(input int s0, input int s1, input int s2, input int s3,
		input bit resync, input bit lock);
		step(0, resync, lock);
		set_skews(s0, s1, s2, s3);
		out_mode = OUT_FREE;
		t = 0;	// Stream restarts so the earliest lane shows the first marker
	endtask

	task automatic align_and_check(input int gap_pct);
		int n;
		n = 0;
		out_mode = OUT_FREE;
		// First beat lets a pending clear reach the outputs
		do
		begin
			step(gap_pct, 1'b0, 1'b1);
			n++;
		end while (!o_deskew_done && n < ALIGN_LIMIT);
		assert (o_deskew_done)
		else
		begin
			$display("Alignment not reached within %0d beats for skews %0d %0d %0d %0d",
				ALIGN_LIMIT, skew[0], skew[1], skew[2], skew[3]);
			errors++;
		end
		if (o_deskew_done)
		begin
			out_mode = OUT_LOCKED;
			markers_seen = 0;
			repeat (CHECK_BEATS) step(gap_pct, 1'b0, 1'b1);
			assert (markers_seen > 0)
			else
			begin
				$display("No aligned marker came out while the lanes were locked");
				errors++;
			end
		end
	endtask

	task automatic report_test(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("%s: pass", name);
		else
			$display("%s: %0d errors", name, errors - err0);
	endtask

	task automatic zero_skew_test();
		int err0;
		err0 = errors;
		start_test(0, 0, 0, 0, 1'b1, 1'b1);
		align_and_check(0);
		report_test("zero_skew", err0);
	endtask

	task automatic skewed_lanes_test();
		int err0;
		err0 = errors;
		start_test(0, 3, 7, 5, 1'b1, 1'b1);
		align_and_check(0);
		report_test("skewed_lanes", err0);
	endtask

	// Lane 2 lags by the full limit, then moves to a legal skew while searching
	task automatic invalid_skew_test();
		int err0;
		int n;
		err0 = errors;
		start_test(0, 0, MAX_SKEW, 0, 1'b1, 1'b1);
		out_mode = OUT_NONE;
		n = 0;
		while (!o_invalid_skew && n < 40)
		begin
			step(0, 1'b0, 1'b1);
			n++;
		end
		assert (o_invalid_skew)
		else
		begin
			$display("The skew limit was never flagged with lane 2 late by %0d beats", MAX_SKEW);
			errors++;
		end
		while (t < 24)
			step(0, 1'b0, 1'b1);
		assert (!o_invalid_skew)
		else
		begin
			$display("The skew flag stayed high after the search restarted");
			errors++;
		end
		set_skews(0, 0, 4, 2);	// No marker is pending at this point
		align_and_check(0);
		report_test("invalid_skew", err0);
	endtask

	task automatic resync_test();
		int err0;
		err0 = errors;
		start_test(2, 0, 6, 1, 1'b1, 1'b1);
		align_and_check(0);
		start_test(5, 9, 0, 4, 1'b0, 1'b0);	// Lock loss this time
		align_and_check(0);
		report_test("resync_lock_loss", err0);
	endtask

	task automatic valid_gap_test();
		int err0;
		err0 = errors;
		start_test(0, 3, 7, 5, 1'b1, 1'b1);
		align_and_check(25);
		report_test("valid_gaps", err0);
	endtask

	initial
	begin
		i_rst_n      = 1'b0;
		i_valid      = 1'b0;
		i_resync     = 1'b0;
		i_am_lock    = 1'b1;
		i_lane_start = '0;
		i_lane_data  = '0;
		errors       = 0;
		tests_run    = 0;
		t            = 0;
		prev_t       = 0;
		prev_valid   = 1'b0;
		prev_clear   = 1'b0;
		out_mode     = OUT_FREE;
		markers_seen = 0;
		rng          = SEED;
		for (int k = 0; k < REF_DEPTH; k++)
		begin
			rng = lcg_next(rng);
			ref_words[k] = rng[31:16];
		end
		set_skews(0, 0, 0, 0);
		repeat (8) @(posedge i_clock);
		#1;
		i_rst_n = 1'b1;

		zero_skew_test();
		skewed_lanes_test();
		invalid_skew_test();
		resync_test();
		valid_gap_test();

		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== deskew.f ====
logic/deskew_pkg.sv
logic/deskew_fsm.sv
logic/skew_counters.sv
logic/lane_delay_fifo.sv
logic/lane_deskew_top.sv
dv/deskew_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Mdir $(OBJ_DIR)
TOP      = deskew_tb
FILELIST = deskew.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
